// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, fail if the log reports a failure"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f carbon_sys.f --top-module carbon_sys_tb
	./obj_dir/Vcarbon_sys_tb | tee sim.log
	@! grep -q "RESULT: FAIL" sim.log
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/carbon_sys_tb.sv ====
`timescale 1ns/10ps
// Carbon system testbench
// Host traffic during and after boot, checked against a memory-map model
module carbon_sys_tb;

  localparam int RAM_OPS = 64;
  localparam int ARB_OPS = 8;
  // Reset, boot and about 180 host accesses stay below 300 cycles
  localparam int TIMEOUT_CYCLES = 3000;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  host_req_valid;
  logic                  host_req_ready;
  logic                  host_req_write;
  carbon_sys_pkg::addr_t host_req_addr;
  carbon_sys_pkg::data_t host_req_wdata;
  logic                  host_rsp_valid;
  carbon_sys_pkg::data_t host_rsp_rdata;
  carbon_sys_pkg::data_t signature;
  logic                  poweroff;
  logic                  boot_done;

  // Memory-map model
  logic [31:0] ram_model [256];
  logic [31:0] sig_model;
  logic [31:0] scratch_model;
  logic        off_model;

  logic [31:0] exp_q [$];
  logic [31:0] arb_addr [$];
  logic [31:0] ram_addr [$];
  logic [31:0] lcg_state;
  logic        rsp_due;
  string       cur_test;
  int          test_errs;
  int          tests_pass;
  int          tests_fail;
  int          cycles = 0;
  int          accept_cycle;

  carbon_sys_top dut_i (
    .clk            (clk),
    .rst            (rst),
    .host_req_valid (host_req_valid),
    .host_req_ready (host_req_ready),
    .host_req_write (host_req_write),
    .host_req_addr  (host_req_addr),
    .host_req_wdata (host_req_wdata),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_rdata (host_rsp_rdata),
    .signature      (signature),
    .poweroff       (poweroff),
    .boot_done      (boot_done)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s, sequencer state %s",
               cycles, cur_test, dut_i.u_seq.state.name());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Model, random source and error reporting
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    if ((addr & 32'hFFFF_FF00) != 32'hF000_0000) return ram_model[addr[9:2]];
    case (addr[7:0])
      8'h00:   return sig_model;
      8'h04:   return {31'd0, off_model};
      8'h08:   return scratch_model;
      default: return 32'd0;
    endcase
  endfunction

  function automatic void model_write(input logic [31:0] addr, input logic [31:0] data);
    if ((addr & 32'hFFFF_FF00) != 32'hF000_0000) ram_model[addr[9:2]] = data;
    else if (addr[7:0] == 8'h00) sig_model = data;
    else if (addr[7:0] == 8'h04) off_model = data[0];
    else if (addr[7:0] == 8'h08) scratch_model = data;
  endfunction

  task automatic value_error(input logic [31:0] expect_val, input logic [31:0] actual);
    test_errs++;
    $display("Fail %s expected %h actual %h", cur_test, expect_val, actual);
  endtask

  task automatic other_error(input string what);
    test_errs++;
    $display("Error in %s: %s", cur_test, what);
  endtask

  // Issue one request and hold it until the fabric grants it
  task automatic host_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata);
    host_req_valid = 1'b1;
    host_req_write = wr;
    host_req_addr  = addr;
    host_req_wdata = wdata;
    @(negedge clk);
    while (!host_req_ready) @(negedge clk);
    accept_cycle = cycles;
    if (wr) begin
      model_write(addr, wdata);
      exp_q.push_back(32'd0);
    end else begin
      exp_q.push_back(expected_read(addr));
    end
    @(posedge clk);
    #1;
    host_req_valid = 1'b0;
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    repeat (2) @(negedge clk);
    assert (exp_q.size() == 0) else other_error("host responses missing");
    if (test_errs == 0) begin
      tests_pass++;
      $display("Test %s ok", cur_test);
    end else begin
      tests_fail++;
      $display("Test %s has %0d errors", cur_test, test_errs);
    end
    @(posedge clk);
    #1;
  endtask

  // Response strobe is due one cycle after each acceptance and its data comes from the model
  always @(negedge clk) begin : compare_rsp
    logic [31:0] expect_val;
    assert (host_rsp_valid == rsp_due)
      else other_error("response strobe not one cycle after acceptance");
    if (host_rsp_valid && exp_q.size() > 0) begin
      expect_val = exp_q.pop_front();
      assert (host_rsp_rdata == expect_val) else value_error(expect_val, host_rsp_rdata);
    end
    rsp_due = host_req_valid && host_req_ready;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int prev_cycle;
    rst            = 1'b1;
    host_req_valid = 1'b0;
    host_req_write = 1'b0;
    host_req_addr  = '0;
    host_req_wdata = '0;
    rsp_due        = 1'b0;
    lcg_state      = 32'hc00b;
    tests_pass     = 0;
    tests_fail     = 0;
    // Boot script leaves a RAM marker, the signature and poweroff set
    ram_model      = '{default: 32'd0};
    ram_model[8'h10] = 32'h5A5A_0001;
    sig_model      = 32'h5A38_3021;
    off_model      = 1'b1;
    scratch_model  = 32'd0;
    start_test("arbitration");
    repeat (16) @(posedge clk);
    #1;
    assert (!host_req_ready && !host_rsp_valid && !poweroff && !boot_done && signature == 0)
      else other_error("outputs not idle in reset");
    rst = 1'b0;
    // Host writes compete with the sequencer for the fabric
    // RAM index 10 hex stays with the boot script
    for (int i = 0; i < ARB_OPS; i++) begin
      arb_addr.push_back(lcg_next() & 32'h0000_03FC);
      if (arb_addr[i][9:2] == 8'h10) arb_addr[i] = arb_addr[i] ^ 32'h4;
      host_access(1'b1, arb_addr[i], lcg_next());
    end
    while (!boot_done) @(negedge clk);
    @(posedge clk);
    #1;
    for (int i = 0; i < ARB_OPS; i++) host_access(1'b0, arb_addr[i], 32'd0);
    assert (signature == sig_model) else value_error(sig_model, signature);
    end_test();

    start_test("boot");
    assert (boot_done) else other_error("boot_done is low");
    assert (signature == 32'h5A38_3021) else value_error(32'h5A38_3021, signature);
    assert (poweroff) else other_error("poweroff was not set by the boot script");
    end_test();

    start_test("boot_ram");
    host_access(1'b0, 32'h0000_0040, 32'd0);
    end_test();

    start_test("ram_random");
    for (int i = 0; i < RAM_OPS; i++) begin
      ram_addr.push_back(lcg_next() & 32'h0FFF_FFFC);
      host_access(1'b1, ram_addr[i], lcg_next());
    end
    // Odd reads go through the alias 1 KiB away
    for (int i = 0; i < RAM_OPS; i++) begin
      host_access(1'b0, ram_addr[i] ^ {21'd0, i[0], 10'd0}, 32'd0);
    end
    end_test();

    start_test("mmio");
    host_access(1'b1, 32'hF000_0008, lcg_next());
    host_access(1'b0, 32'hF000_0008, 32'd0);
    host_access(1'b1, 32'hF000_0004, 32'd0);
    host_access(1'b1, 32'hF000_000C, lcg_next());
    host_access(1'b0, 32'hF000_000C, 32'd0);
    host_access(1'b0, 32'hF000_0000, 32'd0);
    @(negedge clk);
    assert (!poweroff) else other_error("poweroff still high after it was cleared");
    end_test();

    start_test("back_to_back");
    host_access(1'b0, ram_addr[0], 32'd0);
    for (int i = 1; i < 8; i++) begin
      prev_cycle = accept_cycle;
      host_access(1'b0, ram_addr[i], 32'd0);
      assert (accept_cycle == prev_cycle + 1)
        else other_error("host request not accepted on the next cycle");
    end
    end_test();

    $display("Tests passed: %0d, failed: %0d", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule : carbon_sys_tb

// ==== carbon_sys.f ====
hw/carbon_sys_pkg.sv
hw/fabric_if.sv
hw/delay_timer.sv
hw/fabric_arbiter.sv
hw/boot_sequencer.sv
hw/sram.sv
hw/mmio_regs.sv
hw/carbon_sys_top.sv
bench/carbon_sys_tb.sv

// ==== hw/boot_sequencer.sv ====
`timescale 1ns/10ps
// Boot sequencer
// Walks the boot script as a bus master, then holds boot_done
module boot_sequencer (
  input  logic     clk,
  input  logic     rst,
  fabric_if.master bus,
  output logic     boot_done
);

  carbon_sys_pkg::boot_state_t           state;
  logic [carbon_sys_pkg::BOOT_PTR_W-1:0] ptr;
  carbon_sys_pkg::op_t                   op;
  carbon_sys_pkg::data_t                 arg;
  logic                                  timer_load;
  logic                                  timer_busy;
  logic                                  timer_done;

  assign op  = carbon_sys_pkg::BOOT_OP[ptr];
  assign arg = carbon_sys_pkg::BOOT_ARG[ptr];

  // Wait entries carry their length in the low half of the argument
  assign timer_load = (state == carbon_sys_pkg::S_FETCH) &&
                      (op == carbon_sys_pkg::OP_WAIT) && !timer_busy;

  delay_timer u_delay (
    .clk    (clk),
    .rst    (rst),
    .load   (timer_load),
    .length (arg[15:0]),
    .busy   (timer_busy),
    .done   (timer_done)
  );

  // Script only issues writes
  assign bus.req_valid = (state == carbon_sys_pkg::S_ISSUE);
  assign bus.req_write = 1'b1;
  assign bus.req_addr  = carbon_sys_pkg::BOOT_ADDR[ptr];
  assign bus.req_wdata = arg;

  assign boot_done = (state == carbon_sys_pkg::S_DONE);

  // ----------------------------------------------------------------------
  // Script FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= carbon_sys_pkg::S_FETCH;
      ptr   <= '0;
    end else begin
      case (state)
        carbon_sys_pkg::S_FETCH: begin
          if (op == carbon_sys_pkg::OP_WRITE) begin
            state <= carbon_sys_pkg::S_ISSUE;
          end else if (op == carbon_sys_pkg::OP_WAIT) begin
            if (timer_load) state <= carbon_sys_pkg::S_DELAY;
          end else begin
            state <= carbon_sys_pkg::S_DONE;
          end
        end
        carbon_sys_pkg::S_ISSUE: begin
          if (bus.req_ready) state <= carbon_sys_pkg::S_RESP;
        end
        carbon_sys_pkg::S_RESP: begin
          // Next entry only once the write is acknowledged
          if (bus.rsp_valid) begin
            ptr   <= ptr + 1'b1;
            state <= carbon_sys_pkg::S_FETCH;
          end
        end
        carbon_sys_pkg::S_DELAY: begin
          if (timer_done) begin
            ptr   <= ptr + 1'b1;
            state <= carbon_sys_pkg::S_FETCH;
          end
        end
        default: state <= carbon_sys_pkg::S_DONE;
      endcase
    end
  end

endmodule : boot_sequencer

// ==== hw/carbon_sys_pkg.sv ====
// Carbon system shared definitions
// Bus widths, address map, MMIO register offsets and the boot script
package carbon_sys_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  ram_idx_t;
  typedef logic [15:0] delay_t;
  typedef logic [1:0]  op_t;

  localparam op_t OP_WRITE = 2'd0;
  localparam op_t OP_WAIT  = 2'd1;
  localparam op_t OP_HALT  = 2'd2;

  // MMIO window, everything outside it decodes to RAM
  localparam addr_t MMIO_BASE = 32'hF000_0000;
  localparam addr_t MMIO_MASK = 32'hFFFF_FF00;

  localparam logic [7:0] MMIO_SIG_OFS     = 8'h00;
  localparam logic [7:0] MMIO_OFF_OFS     = 8'h04;
  localparam logic [7:0] MMIO_SCRATCH_OFS = 8'h08;

  localparam int RAM_WORDS = 256;

  // Boot script: RAM marker, short wait, signature, then poweroff
  localparam int BOOT_LEN   = 5;
  localparam int BOOT_PTR_W = $clog2(BOOT_LEN);

  localparam op_t BOOT_OP [BOOT_LEN] = '{OP_WRITE, OP_WAIT, OP_WRITE, OP_WRITE, OP_HALT};
  localparam addr_t BOOT_ADDR [BOOT_LEN] = '{
    32'h0000_0040, 32'h0000_0000, MMIO_BASE | 32'(MMIO_SIG_OFS),
    MMIO_BASE | 32'(MMIO_OFF_OFS), 32'h0000_0000
  };
  localparam data_t BOOT_ARG [BOOT_LEN] = '{
    32'h5A5A_0001, 32'd20, 32'h5A38_3021, 32'h0000_0001, 32'h0000_0000
  };

  typedef enum logic [2:0] {S_FETCH, S_ISSUE, S_RESP, S_DELAY, S_DONE} boot_state_t;

endpackage : carbon_sys_pkg

// ==== hw/carbon_sys_top.sv ====
`timescale 1ns/10ps
// Carbon system top
// Host port and boot sequencer sharing one fabric in front of MMIO and RAM
module carbon_sys_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  host_req_valid,
  output logic                  host_req_ready,
  input  logic                  host_req_write,
  input  carbon_sys_pkg::addr_t host_req_addr,
  input  carbon_sys_pkg::data_t host_req_wdata,
  output logic                  host_rsp_valid,
  output carbon_sys_pkg::data_t host_rsp_rdata,
  output carbon_sys_pkg::data_t signature,
  output logic                  poweroff,
  output logic                  boot_done
);

  fabric_if m_seq ();
  fabric_if s_mmio ();
  fabric_if s_ram ();

  // ----------------------------------------------------------------------
  // Masters and fabric
  // ----------------------------------------------------------------------
  boot_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .bus       (m_seq),
    .boot_done (boot_done)
  );

  fabric_arbiter u_fabric (
    .clk            (clk),
    .rst            (rst),
    .host_req_valid (host_req_valid),
    .host_req_write (host_req_write),
    .host_req_addr  (host_req_addr),
    .host_req_wdata (host_req_wdata),
    .host_req_ready (host_req_ready),
    .host_rsp_valid (host_rsp_valid),
    .host_rsp_rdata (host_rsp_rdata),
    .seq            (m_seq),
    .mmio           (s_mmio),
    .ram            (s_ram)
  );

  // ----------------------------------------------------------------------
  // Slaves
  // ----------------------------------------------------------------------
  sram u_ram (
    .clk (clk),
    .rst (rst),
    .bus (s_ram)
  );

  mmio_regs u_mmio (
    .clk       (clk),
    .rst       (rst),
    .bus       (s_mmio),
    .signature (signature),
    .poweroff  (poweroff)
  );

endmodule : carbon_sys_top

// ==== hw/delay_timer.sv ====
`timescale 1ns/10ps
// Delay timer, loadable down-counter with a one-cycle done pulse
module delay_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   load,
  input  carbon_sys_pkg::delay_t length,
  output logic                   busy,
  output logic                   done
);

  carbon_sys_pkg::delay_t cnt;

  assign busy = (cnt != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt  <= '0;
      done <= 1'b0;
    end else if (load) begin
      cnt  <= length;
      // Zero length still gives one pulse
      done <= (length == '0);
    end else begin
      done <= (cnt == 16'd1);
      if (busy) cnt <= cnt - 1'b1;
    end
  end

endmodule : delay_timer

// ==== hw/fabric_arbiter.sv ====
`timescale 1ns/10ps
// Two-master fabric arbiter
// Round-robin grant between host and sequencer, MMIO/RAM decode, response routing
module fabric_arbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  host_req_valid,
  input  logic                  host_req_write,
  input  carbon_sys_pkg::addr_t host_req_addr,
  input  carbon_sys_pkg::data_t host_req_wdata,
  output logic                  host_req_ready,
  output logic                  host_rsp_valid,
  output carbon_sys_pkg::data_t host_rsp_rdata,
  fabric_if.slave               seq,
  fabric_if.master              mmio,
  fabric_if.master              ram
);

  logic                  last_host;
  logic                  grant_host;
  logic                  grant_seq;
  logic                  any_grant;
  logic                  hit_mmio;
  logic                  slave_ready;
  logic                  accept;
  logic                  sel_write;
  carbon_sys_pkg::addr_t sel_addr;
  carbon_sys_pkg::data_t sel_wdata;
  logic                  tag_host;
  logic                  tag_mmio;
  logic                  rsp_valid;
  carbon_sys_pkg::data_t rsp_rdata;

  // ----------------------------------------------------------------------
  // Grant and request steering
  // ----------------------------------------------------------------------
  // On contention the master that was not served last wins
  assign grant_host = host_req_valid && (!seq.req_valid || !last_host);
  assign grant_seq  = seq.req_valid && !grant_host;
  assign any_grant  = grant_host || grant_seq;

  assign sel_write = grant_host ? host_req_write : seq.req_write;
  assign sel_addr  = grant_host ? host_req_addr  : seq.req_addr;
  assign sel_wdata = grant_host ? host_req_wdata : seq.req_wdata;

  assign hit_mmio = (sel_addr & carbon_sys_pkg::MMIO_MASK) == carbon_sys_pkg::MMIO_BASE;

  assign mmio.req_valid = any_grant && hit_mmio;
  assign mmio.req_write = sel_write;
  assign mmio.req_addr  = sel_addr;
  assign mmio.req_wdata = sel_wdata;

  // RAM is the default slave
  assign ram.req_valid = any_grant && !hit_mmio;
  assign ram.req_write = sel_write;
  assign ram.req_addr  = sel_addr;
  assign ram.req_wdata = sel_wdata;

  assign slave_ready    = hit_mmio ? mmio.req_ready : ram.req_ready;
  assign accept         = any_grant && slave_ready;
  assign host_req_ready = grant_host && slave_ready;
  assign seq.req_ready  = grant_seq && slave_ready;

  // ----------------------------------------------------------------------
  // Response routing by the tag of the last accepted request
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      last_host <= 1'b0;
      tag_host  <= 1'b0;
      tag_mmio  <= 1'b0;
    end else if (accept) begin
      last_host <= grant_host;
      tag_host  <= grant_host;
      tag_mmio  <= hit_mmio;
    end
  end

  assign rsp_valid = tag_mmio ? mmio.rsp_valid : ram.rsp_valid;
  assign rsp_rdata = tag_mmio ? mmio.rsp_rdata : ram.rsp_rdata;

  assign host_rsp_valid = rsp_valid && tag_host;
  assign host_rsp_rdata = rsp_rdata;
  assign seq.rsp_valid  = rsp_valid && !tag_host;
  assign seq.rsp_rdata  = rsp_rdata;

endmodule : fabric_arbiter

// ==== hw/fabric_if.sv ====
`timescale 1ns/10ps
// Fabric bus interface
// Valid/ready request channel with a strobe-only response channel
interface fabric_if;

  logic                  req_valid;
  logic                  req_ready;
  logic                  req_write;
  carbon_sys_pkg::addr_t req_addr;
  carbon_sys_pkg::data_t req_wdata;
  logic                  rsp_valid;
  carbon_sys_pkg::data_t rsp_rdata;

  modport master (
    output req_valid, req_write, req_addr, req_wdata,
    input  req_ready, rsp_valid, rsp_rdata
  );

  // Mirror of the master side
  modport slave (
    input  req_valid, req_write, req_addr, req_wdata,
    output req_ready, rsp_valid, rsp_rdata
  );

endinterface : fabric_if

// ==== hw/mmio_regs.sv ====
`timescale 1ns/10ps
// MMIO register block
// Signature, poweroff and scratch registers with one cycle response latency
module mmio_regs (
  input  logic                  clk,
  input  logic                  rst,
  fabric_if.slave               bus,
  output carbon_sys_pkg::data_t signature,
  output logic                  poweroff
);

  carbon_sys_pkg::data_t sig_q;
  carbon_sys_pkg::data_t scratch_q;
  logic                  off_q;
  logic [7:0]            ofs;
  logic                  accept;

  assign ofs           = bus.req_addr[7:0];
  assign bus.req_ready = 1'b1;
  assign accept        = bus.req_valid && bus.req_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      sig_q         <= '0;
      scratch_q     <= '0;
      off_q         <= 1'b0;
      bus.rsp_valid <= 1'b0;
    end else begin
      bus.rsp_valid <= accept;
      // Unmapped offsets drop the write
      if (accept && bus.req_write) begin
        if (ofs == carbon_sys_pkg::MMIO_SIG_OFS)     sig_q     <= bus.req_wdata;
        if (ofs == carbon_sys_pkg::MMIO_OFF_OFS)     off_q     <= bus.req_wdata[0];
        if (ofs == carbon_sys_pkg::MMIO_SCRATCH_OFS) scratch_q <= bus.req_wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req_write)                               bus.rsp_rdata <= '0;
    else if (ofs == carbon_sys_pkg::MMIO_SIG_OFS)     bus.rsp_rdata <= sig_q;
    else if (ofs == carbon_sys_pkg::MMIO_OFF_OFS)     bus.rsp_rdata <= {31'd0, off_q};
    else if (ofs == carbon_sys_pkg::MMIO_SCRATCH_OFS) bus.rsp_rdata <= scratch_q;
    else                                             bus.rsp_rdata <= '0;
  end

  assign signature = sig_q;
  assign poweroff  = off_q;

endmodule : mmio_regs

// ==== hw/sram.sv ====
`timescale 1ns/10ps
// Word-addressed RAM slave, 256 words, one cycle response latency
module sram (
  input  logic    clk,
  input  logic    rst,
  fabric_if.slave bus
);

  carbon_sys_pkg::data_t    mem [carbon_sys_pkg::RAM_WORDS];
  carbon_sys_pkg::ram_idx_t idx;
  logic                     accept;

  // Upper address bits are ignored so the array aliases
  assign idx           = bus.req_addr[9:2];
  assign bus.req_ready = 1'b1;
  assign accept        = bus.req_valid && bus.req_ready;

  always_ff @(posedge clk) begin
    if (accept && bus.req_write) mem[idx] <= bus.req_wdata;
    bus.rsp_rdata <= bus.req_write ? '0 : mem[idx];
  end

  always_ff @(posedge clk) begin
    if (rst) bus.rsp_valid <= 1'b0;
    else     bus.rsp_valid <= accept;
  end

endmodule : sram
